/* Bender.yml */
package:
  name: ecc_dsa

sources:
  - include_dirs:
      - include
    files:
      - rtl/ecc_pkg.sv
      - rtl/ecc_uop_if.sv
      - rtl/ecc_apb_regs.sv
      - rtl/ecc_uop_decode.sv
      - rtl/ecc_arith_unit.sv
      - rtl/ecc_scalar_blind.sv
      - rtl/ecc_dsa_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/ecc_dsa_sva.sv
      - bench/tb_ecc_dsa.sv

/* bench/ecc_dsa_sva.sv */
// bound assertions on APB and command timing of the ECC controller

`timescale 1ns/10ps

module ecc_dsa_sva
    import ecc_pkg::*;
(
    input logic     clk,
    input logic     reset_n,
    input logic     pready_i,
    input logic     notif_intr_i,
    input logic     busy_i,
    input ecc_cmd_e cmd_i
);
    int unsigned fail_cnt = 0;

    // zero wait state slave
    pready_high: assert property (@(posedge clk) disable iff (!reset_n) pready_i)
        else begin
            $error("pready_o went low");
            fail_cnt++;
        end

    intr_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
                                     notif_intr_i |=> !notif_intr_i)
        else begin
            $error("notif_intr_o held for more than one cycle");
            fail_cnt++;
        end

    // a command pulse reaches the sequencer only while it idles
    busy_cmd_refused: assert property (@(posedge clk) disable iff (!reset_n)
                                       (cmd_i != NOP) |-> !busy_i)
        else begin
            $error("command accepted while busy");
            fail_cnt++;
        end
endmodule

bind ecc_dsa_top ecc_dsa_sva i_sva (
    .clk(clk), .reset_n(reset_n),
    .pready_i(pready_o), .notif_intr_i(notif_intr_o),
    .busy_i(busy), .cmd_i(cmd)
);

/* bench/tb_ecc_dsa.sv */
// testbench for the ECC controller
// clock, reset, APB tasks, reference model, result comparison, watchdog

`timescale 1ns/10ps
`include "ecc_cfg.svh"

module tb_ecc_dsa
    import ecc_pkg::*;
();
    localparam int CLK_PERIOD = 4;
    localparam int NUM_CMDS   = 40;
    localparam int CMD_LIMIT  = 200;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        notif_intr;

    integer      seed = 24;
    int          intr_cnt = 0;
    ecc_word_t   got_q[$];
    ecc_word_t   exp_q[$];
    string       name_q[$];

    ecc_dsa_top i_dut (
        .clk(clk), .reset_n(reset_n),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr), .notif_intr_o(notif_intr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // reporting and checks
    // --------------------------------------------------
    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input ecc_word_t got, input ecc_word_t exp);
        if (got !== exp) begin
            $display("Fail at %t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // expected pubkey or s
    // blinding and masking do not change the result
    function automatic ecc_word_t ref_ecc(input ecc_cmd_e cmd, input ecc_operands_t ops);
        logic [63:0] prod;
        if (cmd == KEYGEN) begin
            prod = 64'(ops.privkey) * 64'(`ECC_GEN_G);
            return ecc_word_t'(prod % 64'(`ECC_ORDER_Q));
        end
        prod = (64'(ops.privkey) * 64'(ops.nonce)) % 64'(`ECC_PRIME_P);
        return ecc_word_t'((prod + 64'(ops.msg)) % 64'(`ECC_PRIME_P));
    endfunction

    // --------------------------------------------------
    // APB access with read data sampled mid access phase
    // --------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_bit("pready_o", pready, 1'b1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_cmd(input ecc_cmd_e cmd, input logic [1:0] sca, input ecc_operands_t ops);
        logic [31:0] rdata;
        logic        err;
        int          intr_before;
        int          cycles;
        apb_xfer(1'b1, `ECC_OFS_PRIVKEY, ops.privkey, rdata, err);
        apb_xfer(1'b1, `ECC_OFS_MSG, ops.msg, rdata, err);
        apb_xfer(1'b1, `ECC_OFS_NONCE, ops.nonce, rdata, err);
        apb_xfer(1'b1, `ECC_OFS_SCACONFIG, {30'd0, sca}, rdata, err);
        intr_before = intr_cnt;
        apb_xfer(1'b1, `ECC_OFS_CTRL, {30'd0, cmd}, rdata, err);
        check_bit("pslverr_o", err, 1'b0);
        apb_xfer(1'b0, `ECC_OFS_STATUS, '0, rdata, err);
        check_bit("STATUS.READY", rdata[0], 1'b0);
        check_bit("STATUS.VALID", rdata[1], 1'b0);
        // a second command while busy is refused
        apb_xfer(1'b1, `ECC_OFS_CTRL, {30'd0, cmd}, rdata, err);
        check_bit("pslverr_o", err, 1'b1);
        cycles = 0;
        while (intr_cnt == intr_before) begin
            @(posedge clk);
            cycles++;
            if (cycles > CMD_LIMIT) begin
                $display("%s did not finish within %0d cycles", cmd.name(), CMD_LIMIT);
                stop_on_error();
            end
        end
        apb_xfer(1'b0, `ECC_OFS_STATUS, '0, rdata, err);
        check_bit("STATUS.READY", rdata[0], 1'b1);
        check_bit("STATUS.VALID", rdata[1], 1'b1);
        check_word("notif_intr_o pulses", ecc_word_t'(intr_cnt - intr_before), 32'd1);
        apb_xfer(1'b0, (cmd == KEYGEN) ? `ECC_OFS_PUBKEY : `ECC_OFS_SIGN_S, '0, rdata, err);
        name_q.push_back((cmd == KEYGEN) ? "PUBKEY" : "SIGN_S");
        got_q.push_back(rdata);
        exp_q.push_back(ref_ecc(cmd, ops));
    endtask

    // count done pulses where the level is stable
    always @(negedge clk) begin
        if (notif_intr === 1'b1) begin
            intr_cnt++;
        end
    end

    // compare read results against the reference
    initial begin
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                check_word(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_sva.fail_cnt != 0) begin
            $display("a bound assertion on the DUT failed at %t", $time);
            stop_on_error();
        end
    end

    initial begin
        #(NUM_CMDS * CMD_LIMIT * CLK_PERIOD);
        $display("watchdog expired, the run exceeded %0d commands of time", NUM_CMDS);
        stop_on_error();
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        ecc_operands_t ops;
        logic [31:0]   rdata;
        logic          err;
        $timeformat(-9, 2, " ns", 10);
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        apb_xfer(1'b0, `ECC_OFS_STATUS, '0, rdata, err);
        check_bit("STATUS.READY", rdata[0], 1'b1);
        check_bit("STATUS.VALID", rdata[1], 1'b0);
        check_word("notif_intr_o pulses", ecc_word_t'(intr_cnt), 32'd0);

        // KEYGEN plain with a corner key and then blinded
        run_cmd(KEYGEN, 2'b00, '{privkey: 32'hFFFFFFFF, msg: 32'h0, nonce: 32'h0});
        for (int i = 0; i < 6; i++) begin
            ops = {$random(seed), $random(seed), $random(seed)};
            run_cmd(KEYGEN, 2'b00, ops);
        end
        for (int i = 0; i < 8; i++) begin
            ops = {$random(seed), $random(seed), $random(seed)};
            run_cmd(KEYGEN, 2'b01, ops);
        end

        // SIGN plain and masked with operands above P
        ops = '{privkey: 32'hFFFFFFFF, msg: 32'hFFFFFFFF, nonce: 32'hFFFFFFFF};
        run_cmd(SIGN, 2'b00, ops);
        run_cmd(SIGN, 2'b10, ops);
        for (int i = 0; i < 8; i++) begin
            ops = {$random(seed), $random(seed), $random(seed)};
            run_cmd(SIGN, 2'b00, ops);
        end
        for (int i = 0; i < 8; i++) begin
            ops = {$random(seed), $random(seed), $random(seed)};
            run_cmd(SIGN, 2'b10, ops);
        end

        // zeroize and unmapped addresses
        apb_xfer(1'b1, `ECC_OFS_ZEROIZE, 32'h1, rdata, err);
        apb_xfer(1'b0, `ECC_OFS_PRIVKEY, '0, rdata, err);
        check_word("PRIVKEY", rdata, 32'h0);
        apb_xfer(1'b0, `ECC_OFS_PUBKEY, '0, rdata, err);
        check_word("PUBKEY", rdata, 32'h0);
        apb_xfer(1'b0, `ECC_OFS_SIGN_S, '0, rdata, err);
        check_word("SIGN_S", rdata, 32'h0);
        apb_xfer(1'b0, 8'h24, '0, rdata, err);
        check_bit("pslverr_o", err, 1'b1);
        apb_xfer(1'b1, 8'h80, 32'h1, rdata, err);
        check_bit("pslverr_o", err, 1'b1);

        repeat (2) @(posedge clk);
        if (i_dut.i_sva.fail_cnt != 0 || got_q.size() != 0) begin
            $display("assertion failures or unchecked results remain at the end");
            stop_on_error();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end
endmodule

/* filelist.f */
+incdir+include
rtl/ecc_pkg.sv
rtl/ecc_uop_if.sv
rtl/ecc_apb_regs.sv
rtl/ecc_uop_decode.sv
rtl/ecc_arith_unit.sv
rtl/ecc_scalar_blind.sv
rtl/ecc_dsa_top.sv
bench/ecc_dsa_sva.sv
bench/tb_ecc_dsa.sv

/* include/ecc_cfg.svh */
// configuration macros for the ECC controller
// word and random widths, moduli, generator and APB register map

`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

`define ECC_WORD_W      32
`define ECC_RND_W       16
`define ECC_PRIME_P     32'hFFFFFFFB
`define ECC_ORDER_Q     32'hFFFFFFC5
`define ECC_GEN_G       32'd7

// APB register offsets
`define ECC_OFS_CTRL      8'h00
`define ECC_OFS_SCACONFIG 8'h04
`define ECC_OFS_STATUS    8'h08
`define ECC_OFS_PRIVKEY   8'h0C
`define ECC_OFS_MSG       8'h10
`define ECC_OFS_NONCE     8'h14
`define ECC_OFS_PUBKEY    8'h18
`define ECC_OFS_SIGN_S    8'h1C
`define ECC_OFS_ZEROIZE   8'h20

`endif

/* rtl/ecc_apb_regs.sv */
// APB register block of the ECC controller
// software registers, result write-back, status and done interrupt

`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_apb_regs
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [7:0]    paddr_i,
    input  logic [31:0]   pwdata_i,
    output logic [31:0]   prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,
    input  logic          busy_i,
    input  logic          done_i,
    input  logic          wb_en_i,
    input  ecc_reg_id_e   wb_id_i,
    input  ecc_word_t     wb_data_i,
    output ecc_cmd_e      cmd_o,
    output logic [1:0]    sca_en_o,
    output logic          zeroize_o,
    output ecc_operands_t operands_o,
    output logic          notif_intr_o
);
    logic      wr_en;
    logic      mapped;
    logic      valid_q;
    logic      valid_next;
    ecc_word_t pubkey_q;
    ecc_word_t sign_s_q;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign pready_o = 1'b1;

    // VALID is set by done and cleared by a new command
    assign valid_next = done_i ? 1'b1 : ((cmd_o != NOP) ? 1'b0 : valid_q);

    // --------------------------------------------------
    // register writes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_o        <= NOP;
            sca_en_o     <= '0;
            zeroize_o    <= 1'b0;
            valid_q      <= 1'b0;
            notif_intr_o <= 1'b0;
            operands_o   <= '0;
            pubkey_q     <= '0;
            sign_s_q     <= '0;
        end else begin
            cmd_o     <= NOP;
            zeroize_o <= wr_en && (paddr_i == `ECC_OFS_ZEROIZE) && pwdata_i[0];
            if (wr_en && (paddr_i == `ECC_OFS_CTRL) && !busy_i) begin
                cmd_o <= ecc_cmd_e'(pwdata_i[1:0]);
            end
            if (wr_en && (paddr_i == `ECC_OFS_SCACONFIG)) begin
                sca_en_o <= pwdata_i[1:0];
            end
            if (zeroize_o) begin
                valid_q      <= 1'b0;
                notif_intr_o <= 1'b0;
                operands_o   <= '0;
                pubkey_q     <= '0;
                sign_s_q     <= '0;
            end else begin
                valid_q      <= valid_next;
                // one-cycle pulse on the rising edge of VALID
                notif_intr_o <= valid_next & ~valid_q;
                if (wr_en && (paddr_i == `ECC_OFS_PRIVKEY)) operands_o.privkey <= pwdata_i;
                if (wr_en && (paddr_i == `ECC_OFS_MSG))     operands_o.msg     <= pwdata_i;
                if (wr_en && (paddr_i == `ECC_OFS_NONCE))   operands_o.nonce   <= pwdata_i;
                if (wb_en_i && (wb_id_i == PUBKEY)) pubkey_q <= wb_data_i;
                if (wb_en_i && (wb_id_i == SIGN_S)) sign_s_q <= wb_data_i;
            end
        end
    end

    // --------------------------------------------------
    // read mux and slave error
    // --------------------------------------------------
    always_comb begin
        prdata_o = '0;
        mapped   = 1'b1;
        case (paddr_i)
            `ECC_OFS_CTRL, `ECC_OFS_SCACONFIG, `ECC_OFS_ZEROIZE: prdata_o = '0;
            `ECC_OFS_STATUS:  prdata_o = {30'd0, valid_q, ~busy_i};
            `ECC_OFS_PRIVKEY: prdata_o = operands_o.privkey;
            `ECC_OFS_MSG:     prdata_o = operands_o.msg;
            `ECC_OFS_NONCE:   prdata_o = operands_o.nonce;
            `ECC_OFS_PUBKEY:  prdata_o = pubkey_q;
            `ECC_OFS_SIGN_S:  prdata_o = sign_s_q;
            default:          mapped   = 1'b0;
        endcase
    end

    assign pslverr_o = psel_i & penable_i &
                       (~mapped | (pwrite_i & (paddr_i == `ECC_OFS_CTRL) & busy_i));
endmodule

/* rtl/ecc_arith_unit.sv */
// arithmetic unit of the ECC controller
// operand memory, serial modular multiplier, modular add/sub, mask LFSR

`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_arith_unit
    import ecc_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     zeroize_i,
    input  logic     mask_en_i,
    ecc_uop_if.slave uop
);
    localparam int        SLOT_W  = $bits(ecc_slot_t);
    localparam int        PAD_W   = `ECC_RND_W;
    localparam ecc_word_t PRIME_P = `ECC_PRIME_P;
    localparam ecc_word_t ORDER_Q = `ECC_ORDER_Q;
    localparam logic [PAD_W-1:0] PAD = '0;

    ecc_slot_t  mem [4];
    ecc_slot_t  mplier;
    ecc_word_t  mcand, acc, acc_next, dbl, modulus, start_mod;
    ecc_word_t  op_a, op_b, red_a, red_b, addsub_res, lfsr;
    logic [5:0] bit_cnt;
    logic [1:0] dst;
    logic       mult_start;

    // one conditional subtraction, input below twice the modulus
    function automatic ecc_word_t mod_red(input logic [`ECC_WORD_W:0] x, input ecc_word_t m);
        if (x >= {1'b0, m}) begin
            return ecc_word_t'(x - {1'b0, m});
        end
        return ecc_word_t'(x);
    endfunction

    // words sit in the upper part of a slot
    assign op_a        = ecc_word_t'(mem[uop.slot_a] >> PAD_W);
    assign op_b        = ecc_word_t'(mem[uop.slot_b] >> PAD_W);
    assign uop.rd_data = op_a;
    assign uop.busy    = (bit_cnt != '0);

    // --------------------------------------------------
    // modular add / subtract mod P
    // --------------------------------------------------
    assign red_a = mod_red({1'b0, op_a}, PRIME_P);
    assign red_b = mod_red({1'b0, op_b}, PRIME_P);

    always_comb begin
        if (uop.opcode == UOP_SUB_P) begin
            addsub_res = (red_a >= red_b) ? red_a - red_b : red_a + (PRIME_P - red_b);
        end else begin
            addsub_res = mod_red({1'b0, red_a} + {1'b0, red_b}, PRIME_P);
        end
    end

    // --------------------------------------------------
    // serial multiplier, msb first, one bit per cycle
    // --------------------------------------------------
    assign mult_start = uop.uop_valid &&
                        ((uop.opcode == UOP_MULT_P) || (uop.opcode == UOP_MULT_Q));
    assign start_mod  = (uop.opcode == UOP_MULT_Q) ? ORDER_Q : PRIME_P;
    assign dbl        = mod_red({acc, 1'b0}, modulus);
    assign acc_next   = mod_red({1'b0, dbl} + ({(`ECC_WORD_W+1){mplier[SLOT_W-1]}} &
                                               {1'b0, mcand}), modulus);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= '0;
            lfsr    <= 32'h1;
        end else if (zeroize_i) begin
            bit_cnt <= '0;
            lfsr    <= 32'h1;
        end else begin
            // free-running galois LFSR for the mask d
            lfsr <= (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
            if (mult_start) begin
                bit_cnt <= uop.wide ? 6'(SLOT_W) : 6'(`ECC_WORD_W);
            end else if (bit_cnt != '0) begin
                bit_cnt <= bit_cnt - 6'd1;
            end
        end
    end

    // --------------------------------------------------
    // operand memory and multiplier datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < 4; i++) begin
                mem[i] <= '0;
            end
        end else if (mult_start) begin
            modulus <= start_mod;
            mcand   <= mod_red({1'b0, op_a}, start_mod);
            acc     <= '0;
            mplier  <= mem[uop.slot_b];
            dst     <= uop.slot_a;
        end else if (bit_cnt != '0) begin
            acc    <= acc_next;
            mplier <= mplier << 1;
            if (bit_cnt == 6'd1) begin
                mem[dst] <= {acc_next, PAD};
            end
        end else if (uop.uop_valid) begin
            case (uop.opcode)
                UOP_WR_CORE: begin
                    if (uop.reg_id == MASK) begin
                        mem[uop.slot_a] <= {(mask_en_i ? lfsr : 32'h0), PAD};
                    end else begin
                        mem[uop.slot_a] <= uop.wr_data;
                    end
                end
                UOP_WR_SCALAR:      mem[uop.slot_a] <= uop.wr_data;
                UOP_ADD_P, UOP_SUB_P: mem[uop.slot_a] <= {addsub_res, PAD};
                default: ;
            endcase
        end
    end
endmodule

/* rtl/ecc_dsa_top.sv */
// top level of the ECC controller with plain APB ports

`timescale 1ns/10ps

module ecc_dsa_top
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        notif_intr_o
);
    ecc_cmd_e      cmd;
    logic [1:0]    sca_en;
    logic          zeroize;
    ecc_operands_t operands;
    logic          busy;
    logic          done;
    logic          wb_en;
    ecc_reg_id_e   wb_id;
    ecc_word_t     wb_data;
    logic          blind_start;
    logic          blind_busy;
    ecc_word_t     scalar;
    ecc_slot_t     blinded;

    ecc_uop_if uop_bus ();

    ecc_apb_regs u_regs (
        .clk(clk), .reset_n(reset_n),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .busy_i(busy), .done_i(done),
        .wb_en_i(wb_en), .wb_id_i(wb_id), .wb_data_i(wb_data),
        .cmd_o(cmd), .sca_en_o(sca_en), .zeroize_o(zeroize),
        .operands_o(operands), .notif_intr_o(notif_intr_o)
    );

    ecc_uop_decode u_decode (
        .clk(clk), .reset_n(reset_n),
        .cmd_i(cmd), .sca_en_i(sca_en), .zeroize_i(zeroize), .operands_i(operands),
        .uop(uop_bus.master),
        .blind_start_o(blind_start), .scalar_o(scalar),
        .blinded_i(blinded), .blind_busy_i(blind_busy),
        .wb_en_o(wb_en), .wb_id_o(wb_id), .wb_data_o(wb_data),
        .busy_o(busy), .done_o(done)
    );

    ecc_arith_unit u_arith (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize),
        .mask_en_i(sca_en[1]), .uop(uop_bus.slave)
    );

    ecc_scalar_blind u_blind (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize),
        .start_i(blind_start), .scalar_i(scalar),
        .blinded_o(blinded), .busy_o(blind_busy)
    );
endmodule

/* rtl/ecc_pkg.sv */
// types shared by the ECC controller
// commands, micro-op opcodes, register ids, operand bundle, microcode word

`include "ecc_cfg.svh"

package ecc_pkg;

    typedef logic [`ECC_WORD_W-1:0] ecc_word_t;

    // operand memory slot, one word plus room for the blinding random
    typedef logic [`ECC_WORD_W+`ECC_RND_W-1:0] ecc_slot_t;

    typedef enum logic [1:0] {
        NOP    = 2'd0,
        KEYGEN = 2'd1,
        SIGN   = 2'd2
    } ecc_cmd_e;

    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_WR_CORE,
        UOP_WR_SCALAR,
        UOP_MULT_P,
        UOP_MULT_Q,
        UOP_ADD_P,
        UOP_SUB_P,
        UOP_RD_CORE
    } ecc_opcode_e;

    typedef enum logic [3:0] {
        CONST_G,
        MSG,
        PRIVKEY,
        NONCE,
        MASK,
        PUBKEY,
        SIGN_S,
        SCALAR
    } ecc_reg_id_e;

    typedef struct packed {
        ecc_word_t privkey;
        ecc_word_t msg;
        ecc_word_t nonce;
    } ecc_operands_t;

    // slot_a is source and destination, last ends the program
    typedef struct packed {
        ecc_opcode_e opcode;
        ecc_reg_id_e reg_id;
        logic [1:0]  slot_a;
        logic [1:0]  slot_b;
        logic        last;
    } ecc_instr_t;

endpackage

/* rtl/ecc_scalar_blind.sv */
// scalar blinding, k + r*Q with r from a 16-bit LFSR

`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_scalar_blind
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  logic      start_i,
    input  ecc_word_t scalar_i,
    output ecc_slot_t blinded_o,
    output logic      busy_o
);
    logic [`ECC_RND_W-1:0] lfsr;
    logic [`ECC_RND_W-1:0] r_bits;
    logic [4:0]            step_cnt;
    ecc_slot_t             acc;
    ecc_slot_t             rq;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr     <= 16'hACE1;
            step_cnt <= '0;
        end else if (zeroize_i) begin
            lfsr     <= 16'hACE1;
            step_cnt <= '0;
        end else if (start_i) begin
            // new r for every blinding
            lfsr     <= (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0);
            step_cnt <= 5'(`ECC_RND_W);
        end else if (step_cnt != '0) begin
            step_cnt <= step_cnt - 5'd1;
        end
    end

    // one bit of r per step, lsb first, adding Q shifted by the bit position
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            acc <= '0;
        end else if (start_i) begin
            acc    <= ecc_slot_t'(scalar_i);
            rq     <= ecc_slot_t'(`ECC_ORDER_Q);
            r_bits <= lfsr;
        end else if (step_cnt != '0) begin
            if (r_bits[0]) begin
                acc <= acc + rq;
            end
            rq     <= rq << 1;
            r_bits <= r_bits >> 1;
        end
    end

    assign blinded_o = acc;
    assign busy_o    = (step_cnt != '0);
endmodule

/* rtl/ecc_uop_decode.sv */
// microcode sequencer of the ECC controller
// program counter FSM, microcode ROM and operand selection

`timescale 1ns/10ps
`include "ecc_cfg.svh"

module ecc_uop_decode
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  ecc_cmd_e      cmd_i,
    input  logic [1:0]    sca_en_i,
    input  logic          zeroize_i,
    input  ecc_operands_t operands_i,
    ecc_uop_if.master     uop,
    output logic          blind_start_o,
    output ecc_word_t     scalar_o,
    input  ecc_slot_t     blinded_i,
    input  logic          blind_busy_i,
    output logic          wb_en_o,
    output ecc_reg_id_e   wb_id_o,
    output ecc_word_t     wb_data_o,
    output logic          busy_o,
    output logic          done_o
);
    localparam logic [4:0] PC_NOP     = 5'd0;
    localparam logic [4:0] PC_KG_S    = 5'd1;
    localparam logic [4:0] PC_SGN_S   = 5'd5;
    localparam logic [4:0] PC_SGN_M_S = 5'd11;
    localparam logic [`ECC_RND_W-1:0] PAD = '0;

    logic [4:0] pc;
    logic       issue;
    ecc_instr_t instr;

    // --------------------------------------------------
    // microcode ROM
    // --------------------------------------------------
    always_comb begin
        case (pc)
            // KEYGEN: pubkey = privkey * G mod Q
            5'd1:  instr = '{UOP_WR_CORE,   CONST_G, 2'd0, 2'd0, 1'b0};
            5'd2:  instr = '{UOP_WR_SCALAR, SCALAR,  2'd1, 2'd0, 1'b0};
            5'd3:  instr = '{UOP_MULT_Q,    SCALAR,  2'd0, 2'd1, 1'b0};
            5'd4:  instr = '{UOP_RD_CORE,   PUBKEY,  2'd0, 2'd0, 1'b1};
            // SIGN: s = msg + privkey * nonce mod P
            5'd5:  instr = '{UOP_WR_CORE,   PRIVKEY, 2'd0, 2'd0, 1'b0};
            5'd6:  instr = '{UOP_WR_CORE,   NONCE,   2'd1, 2'd0, 1'b0};
            5'd7:  instr = '{UOP_MULT_P,    SIGN_S,  2'd0, 2'd1, 1'b0};
            5'd8:  instr = '{UOP_WR_CORE,   MSG,     2'd2, 2'd0, 1'b0};
            5'd9:  instr = '{UOP_ADD_P,     SIGN_S,  2'd0, 2'd2, 1'b0};
            5'd10: instr = '{UOP_RD_CORE,   SIGN_S,  2'd0, 2'd0, 1'b1};
            // masked SIGN: ((priv-d)*nonce + (msg-d)) + (d*nonce + d)
            5'd11: instr = '{UOP_WR_CORE,   MASK,    2'd3, 2'd0, 1'b0};
            5'd12: instr = '{UOP_WR_CORE,   PRIVKEY, 2'd0, 2'd0, 1'b0};
            5'd13: instr = '{UOP_SUB_P,     SIGN_S,  2'd0, 2'd3, 1'b0};
            5'd14: instr = '{UOP_WR_CORE,   NONCE,   2'd1, 2'd0, 1'b0};
            5'd15: instr = '{UOP_MULT_P,    SIGN_S,  2'd0, 2'd1, 1'b0};
            5'd16: instr = '{UOP_WR_CORE,   MSG,     2'd2, 2'd0, 1'b0};
            5'd17: instr = '{UOP_SUB_P,     SIGN_S,  2'd2, 2'd3, 1'b0};
            5'd18: instr = '{UOP_ADD_P,     SIGN_S,  2'd0, 2'd2, 1'b0};
            // copy d into slot 2 before slot 3 is overwritten
            5'd19: instr = '{UOP_SUB_P,     MASK,    2'd2, 2'd2, 1'b0};
            5'd20: instr = '{UOP_ADD_P,     MASK,    2'd2, 2'd3, 1'b0};
            5'd21: instr = '{UOP_MULT_P,    MASK,    2'd3, 2'd1, 1'b0};
            5'd22: instr = '{UOP_ADD_P,     MASK,    2'd3, 2'd2, 1'b0};
            5'd23: instr = '{UOP_ADD_P,     SIGN_S,  2'd0, 2'd3, 1'b0};
            5'd24: instr = '{UOP_RD_CORE,   SIGN_S,  2'd0, 2'd0, 1'b1};
            default: instr = '{UOP_NOP,     CONST_G, 2'd0, 2'd0, 1'b1};
        endcase
    end

    // --------------------------------------------------
    // program counter FSM
    // --------------------------------------------------
    // hold while the multiplier or the blinder works
    assign issue = (pc != PC_NOP) && !uop.busy && !blind_busy_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= PC_NOP;
        end else if (zeroize_i) begin
            pc <= PC_NOP;
        end else if (pc == PC_NOP) begin
            case (cmd_i)
                KEYGEN:  pc <= PC_KG_S;
                SIGN:    pc <= sca_en_i[1] ? PC_SGN_M_S : PC_SGN_S;
                default: pc <= PC_NOP;
            endcase
        end else if (issue) begin
            pc <= instr.last ? PC_NOP : pc + 5'd1;
        end
    end

    // blinding starts together with KEYGEN so the scalar is ready at the write
    assign blind_start_o = (pc == PC_NOP) && (cmd_i == KEYGEN) && sca_en_i[0] && !zeroize_i;
    assign scalar_o      = operands_i.privkey;

    // --------------------------------------------------
    // micro-op drive and operand selection
    // --------------------------------------------------
    assign uop.uop_valid = issue && (instr.opcode != UOP_NOP);
    assign uop.opcode    = instr.opcode;
    assign uop.reg_id    = instr.reg_id;
    assign uop.slot_a    = instr.slot_a;
    assign uop.slot_b    = instr.slot_b;
    assign uop.wide      = sca_en_i[0] && (instr.opcode == UOP_MULT_Q);

    always_comb begin
        uop.wr_data = '0;
        if (instr.opcode == UOP_WR_SCALAR) begin
            uop.wr_data = sca_en_i[0] ? blinded_i : {operands_i.privkey, PAD};
        end else begin
            case (instr.reg_id)
                CONST_G: uop.wr_data = {`ECC_GEN_G, PAD};
                MSG:     uop.wr_data = {operands_i.msg, PAD};
                PRIVKEY: uop.wr_data = {operands_i.privkey, PAD};
                NONCE:   uop.wr_data = {operands_i.nonce, PAD};
                default: uop.wr_data = '0;
            endcase
        end
    end

    assign wb_en_o   = issue && (instr.opcode == UOP_RD_CORE);
    assign wb_id_o   = instr.reg_id;
    assign wb_data_o = uop.rd_data;
    assign busy_o    = (pc != PC_NOP);
    assign done_o    = issue && instr.last;
endmodule

/* rtl/ecc_uop_if.sv */
// micro-operation channel from the decoder to the arithmetic unit

`timescale 1ns/10ps

interface ecc_uop_if
    import ecc_pkg::*;
();
    logic        uop_valid;
    ecc_opcode_e opcode;
    ecc_reg_id_e reg_id;
    logic [1:0]  slot_a;
    logic [1:0]  slot_b;
    // multiplier runs over the full blinded width
    logic        wide;
    ecc_slot_t   wr_data;
    logic        busy;
    ecc_word_t   rd_data;

    modport master (
        output uop_valid, opcode, reg_id, slot_a, slot_b, wide, wr_data,
        input  busy, rd_data
    );

    modport slave (
        input  uop_valid, opcode, reg_id, slot_a, slot_b, wide, wr_data,
        output busy, rd_data
    );
endinterface
